// File: source/mulDivPkg.sv
package mulDivPkg;

   localparam int DefaultWidth = 32;   // Operand width used when the top level sets none.

   // Operation selected by the start strobe.
   typedef enum logic {
      opMul = 1'b0,
      opDiv = 1'b1
   } opcodeT;

   typedef enum logic [1:0] {
      stIdle = 2'd0,
      stRun  = 2'd1,
      stDone = 2'd2
   } stateT;

endpackage

// File: source/mulDivCtrlIf.sv
interface mulDivCtrlIf;
   import mulDivPkg::*;

   logic   load;     // Operands into the working registers.
   logic   step;     // One algorithm step per cycle.
   opcodeT op;
   logic   finish;   // Working registers into the result registers.

   modport ctrl (
      output load,
      output step,
      output op,
      output finish
   );

   modport dpath (
      input load,
      input step,
      input op,
      input finish
   );

   modport count (
      input load,
      input step
   );

endinterface

// File: source/addSub.sv
module addSub #(
   parameter int DataWidth = mulDivPkg::DefaultWidth
) (
   input  logic [DataWidth-1:0] a,
   input  logic [DataWidth-1:0] b,
   input  logic                 sub,
   output logic [DataWidth-1:0] result,
   output logic                 carryOut
);

   logic [DataWidth:0]   carry;
   logic [DataWidth-1:0] bMod;

   assign bMod     = b ^ {DataWidth{sub}};   // Ones complement of b for a subtract.
   assign carry[0] = sub;                    // The +1 that completes the twos complement.

   genvar i;
   for (i = 0; i < DataWidth; i++) begin : gCell
      assign result[i]    = a[i] ^ bMod[i] ^ carry[i];
      assign carry[i + 1] = (a[i] & bMod[i]) | (carry[i] & (a[i] ^ bMod[i]));
   end

   // Carry for an add, borrow for a subtract.
   assign carryOut = carry[DataWidth] ^ sub;

endmodule

// File: source/stepCounter.sv
module stepCounter #(
   parameter int DataWidth = mulDivPkg::DefaultWidth
) (
   input  logic            clk,
   input  logic            rstN,
   mulDivCtrlIf.count      ctrl,
   output logic            last
);

   localparam int CountWidth = $clog2(DataWidth);

   logic [CountWidth-1:0] count;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         count <= '0;
      end else if (ctrl.load) begin
         count <= '0;
      end else if (ctrl.step) begin
         count <= count + 1'b1;
      end
   end

   // High through the final step of an operation.
   assign last = ctrl.step && (count == CountWidth'(DataWidth - 1));

endmodule

// File: source/mulDivControl.sv
module mulDivControl (
   input  logic               clk,
   input  logic               rstN,
   input  logic               start,
   input  mulDivPkg::opcodeT  op,
   input  logic               last,
   mulDivCtrlIf.ctrl          ctrl,
   output logic               busy,
   output logic               done
);
   import mulDivPkg::*;

   stateT  state;
   stateT  stateNext;
   opcodeT opQ;
   logic   lastQ;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
         opQ   <= opMul;
         lastQ <= 1'b0;
      end else begin
         state <= stateNext;
         if (ctrl.load) begin
            opQ <= op;   // Held until the next accepted start.
         end
         lastQ <= last;  // Marks the cycle after the final step.
      end
   end

   always_comb begin
      stateNext = state;
      case (state)
         stIdle: begin
            if (start) begin
               stateNext = stRun;
            end
         end
         stRun: begin
            if (lastQ) begin
               stateNext = stDone;
            end
         end
         stDone: begin
            stateNext = stIdle;
         end
         default: begin
            stateNext = stIdle;
         end
      endcase
   end

   // A start outside idle never reaches the datapath.
   assign ctrl.load   = (state == stIdle) && start;
   assign ctrl.step   = (state == stRun) && !lastQ;
   assign ctrl.finish = (state == stRun) && lastQ;
   assign ctrl.op     = opQ;

   assign busy = (state != stIdle);
   assign done = (state == stDone);

endmodule

// File: source/mulDivDatapath.sv
module mulDivDatapath #(
   parameter int DataWidth = mulDivPkg::DefaultWidth
) (
   input  logic                 clk,
   input  logic                 rstN,
   mulDivCtrlIf.dpath           ctrl,
   input  logic [DataWidth-1:0] operandA,
   input  logic [DataWidth-1:0] operandB,
   output logic [DataWidth-1:0] resultHi,
   output logic [DataWidth-1:0] resultLo
);
   import mulDivPkg::*;

   logic [DataWidth-1:0] operandReg;   // Multiplicand or divisor.
   logic [DataWidth-1:0] accReg;       // Upper product half or partial remainder.
   logic [DataWidth-1:0] lowReg;       // Multiplier bits out, quotient bits in.

   logic                 isDiv;
   logic [DataWidth-1:0] shiftedAcc;
   logic                 shiftOutBit;
   logic [DataWidth-1:0] mulAddend;
   logic [DataWidth-1:0] adderA;
   logic [DataWidth-1:0] adderB;
   logic [DataWidth-1:0] adderSum;
   logic                 adderCarry;
   logic                 keepDiff;

   assign isDiv = (ctrl.op == opDiv);

   // Divide shifts the next dividend bit into the partial remainder first.
   assign shiftedAcc  = {accReg[DataWidth-2:0], lowReg[DataWidth-1]};
   assign shiftOutBit = accReg[DataWidth-1];

   assign mulAddend = lowReg[0] ? operandReg : '0;

   assign adderA = isDiv ? shiftedAcc : accReg;
   assign adderB = isDiv ? operandReg : mulAddend;

   addSub #(
      .DataWidth(DataWidth)
   ) uAdder (
      .a        (adderA),
      .b        (adderB),
      .sub      (isDiv),
      .result   (adderSum),
      .carryOut (adderCarry)
   );

   // The lost top bit means the remainder already exceeds the divisor.
   assign keepDiff = !adderCarry || shiftOutBit;

   always_ff @(posedge clk) begin
      if (ctrl.load) begin
         operandReg <= operandB;
         lowReg     <= operandA;
         accReg     <= '0;
      end else if (ctrl.step) begin
         if (isDiv) begin
            accReg <= keepDiff ? adderSum : shiftedAcc;
            lowReg <= {lowReg[DataWidth-2:0], keepDiff};
         end else begin
            accReg <= {adderCarry, adderSum[DataWidth-1:1]};   // Carry becomes the new top bit.
            lowReg <= {adderSum[0], lowReg[DataWidth-1:1]};
         end
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         resultHi <= '0;
         resultLo <= '0;
      end else if (ctrl.finish) begin
         resultHi <= accReg;
         resultLo <= lowReg;
      end
   end

endmodule

// File: source/mulDivUnit.sv
module mulDivUnit #(
   parameter int DataWidth = mulDivPkg::DefaultWidth
) (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 start,
   input  mulDivPkg::opcodeT    op,
   input  logic [DataWidth-1:0] operandA,
   input  logic [DataWidth-1:0] operandB,
   output logic                 busy,
   output logic                 done,
   output logic [DataWidth-1:0] resultHi,
   output logic [DataWidth-1:0] resultLo
);

   logic last;

   mulDivCtrlIf ctrlBus ();

   mulDivControl uControl (
      .clk   (clk),
      .rstN  (rstN),
      .start (start),
      .op    (op),
      .last  (last),
      .ctrl  (ctrlBus.ctrl),
      .busy  (busy),
      .done  (done)
   );

   stepCounter #(
      .DataWidth(DataWidth)
   ) uCounter (
      .clk  (clk),
      .rstN (rstN),
      .ctrl (ctrlBus.count),
      .last (last)
   );

   mulDivDatapath #(
      .DataWidth(DataWidth)
   ) uDatapath (
      .clk      (clk),
      .rstN     (rstN),
      .ctrl     (ctrlBus.dpath),
      .operandA (operandA),
      .operandB (operandB),
      .resultHi (resultHi),
      .resultLo (resultLo)
   );

endmodule

// File: bench/clockGen.sv
module clockGen #(
   parameter int Period      = 8,
   parameter int ResetCycles = 8
) (
   output logic clk,
   output logic rstN
);

   initial begin
      clk = 1'b0;
      forever #(Period / 2) clk = ~clk;
   end

   initial begin
      rstN = 1'b0;
      repeat (ResetCycles) @(posedge clk);
      #1 rstN = 1'b1;   // Released shortly after an edge as the other inputs are.
   end

endmodule

// File: bench/mulDivBench.sv
module mulDivBench;
   import mulDivPkg::*;

   localparam int DataWidth   = 32;
   localparam int OpTimeout   = 3 * DataWidth;
   localparam int GlobalLimit = 20000;

   logic                 clk;
   logic                 rstN;
   logic                 start;
   opcodeT               op;
   logic [DataWidth-1:0] operandA;
   logic [DataWidth-1:0] operandB;
   logic                 busy;
   logic                 done;
   logic [DataWidth-1:0] resultHi;
   logic [DataWidth-1:0] resultLo;

   int          cycleCount     = 0;
   int          valueErrors    = 0;
   int          protocolErrors = 0;
   int          timeoutErrors  = 0;
   logic [31:0] rngState       = 32'hba871250;

   logic [DataWidth-1:0] expHiQ[$];
   logic [DataWidth-1:0] expLoQ[$];
   int                   expCycleQ[$];

   clockGen #(.Period(8), .ResetCycles(8)) uClock (.clk(clk), .rstN(rstN));

   mulDivUnit #(
      .DataWidth(DataWidth)
   ) i_dut (
      .clk      (clk),
      .rstN     (rstN),
      .start    (start),
      .op       (op),
      .operandA (operandA),
      .operandB (operandB),
      .busy     (busy),
      .done     (done),
      .resultHi (resultHi),
      .resultLo (resultLo)
   );

   always @(posedge clk) cycleCount <= cycleCount + 1;

   function automatic logic [31:0] randWord();
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return rngState;
   endfunction

   // Expected {resultHi, resultLo} as the full product, or as remainder and quotient.
   function automatic logic [2*DataWidth-1:0] refResult(input opcodeT opIn,
                                                      input logic [DataWidth-1:0] a,
                                                      input logic [DataWidth-1:0] b);
      logic [2*DataWidth-1:0] wideA;
      logic [2*DataWidth-1:0] wideB;
      wideA = {{DataWidth{1'b0}}, a};
      wideB = {{DataWidth{1'b0}}, b};
      if (opIn == opMul) begin
         return wideA * wideB;
      end else if (b == '0) begin
         return {a, {DataWidth{1'b1}}};
      end else begin
         return {a % b, a / b};
      end
   endfunction

   task automatic finishRun();
      $display("Errors: value %0d, protocol %0d, timeout %0d",
               valueErrors, protocolErrors, timeoutErrors);
      if (valueErrors + protocolErrors + timeoutErrors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   task automatic waitIdle();
      int waited;
      waited = 0;
      while (busy !== 1'b0 && waited < OpTimeout) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (busy !== 1'b0) begin
         timeoutErrors++;
         $display("Timeout while waiting for the unit to become idle");
      end
   endtask

   // Drives one start strobe and queues what the comparing process must see.
   task automatic issueOp(input opcodeT opIn, input logic [DataWidth-1:0] a,
                          input logic [DataWidth-1:0] b);
      logic [2*DataWidth-1:0] expected;
      expected = refResult(opIn, a, b);
      op       = opIn;
      operandA = a;
      operandB = b;
      start    = 1'b1;
      expHiQ.push_back(expected[2*DataWidth-1:DataWidth]);
      expLoQ.push_back(expected[DataWidth-1:0]);
      expCycleQ.push_back(cycleCount + DataWidth + 2);   // Start edge plus DataWidth+1.
      @(posedge clk);
      #1;
      start    = 1'b0;
      operandA = randWord();   // Operands must not be sampled again.
      operandB = randWord();
   endtask

   task automatic runOp(input opcodeT opIn, input logic [DataWidth-1:0] a,
                        input logic [DataWidth-1:0] b);
      waitIdle();
      issueOp(opIn, a, b);
   endtask

   initial begin : compareProcess
      logic [DataWidth-1:0] heldHi;
      logic [DataWidth-1:0] heldLo;
      logic                 prevDone;
      heldHi   = '0;
      heldLo   = '0;
      prevDone = 1'b0;
      forever begin
         @(negedge clk);
         if (rstN === 1'b1) begin
            if (done === 1'b1) begin
               if (prevDone) begin
                  protocolErrors++;
                  $display("done stayed high for more than one cycle");
               end else if (expCycleQ.size() == 0) begin
                  protocolErrors++;
                  $display("done arrived with no operation pending");
               end else begin
                  if (cycleCount != expCycleQ[0]) begin
                     protocolErrors++;
                     $display("[FAIL] done cycle: expected 0x%h, got 0x%h",
                              expCycleQ[0], cycleCount);
                  end
                  if (resultHi !== expHiQ[0]) begin
                     valueErrors++;
                     $display("[FAIL] resultHi: expected 0x%h, got 0x%h", expHiQ[0], resultHi);
                  end
                  if (resultLo !== expLoQ[0]) begin
                     valueErrors++;
                     $display("[FAIL] resultLo: expected 0x%h, got 0x%h", expLoQ[0], resultLo);
                  end
                  void'(expHiQ.pop_front());
                  void'(expLoQ.pop_front());
                  void'(expCycleQ.pop_front());
               end
               heldHi = resultHi;
               heldLo = resultLo;
            end else begin
               // Results may only move together with done.
               if (resultHi !== heldHi) begin
                  valueErrors++;
                  $display("[FAIL] resultHi: expected 0x%h, got 0x%h", heldHi, resultHi);
                  heldHi = resultHi;
               end
               if (resultLo !== heldLo) begin
                  valueErrors++;
                  $display("[FAIL] resultLo: expected 0x%h, got 0x%h", heldLo, resultLo);
                  heldLo = resultLo;
               end
               if (expCycleQ.size() > 0 && cycleCount > expCycleQ[0] + OpTimeout) begin
                  timeoutErrors++;
                  $display("Timeout: done never arrived for a started operation");
                  void'(expHiQ.pop_front());
                  void'(expLoQ.pop_front());
                  void'(expCycleQ.pop_front());
               end
            end
            prevDone = done;
         end
      end
   end

   initial begin : stimulus
      logic [DataWidth-1:0] a;
      logic [DataWidth-1:0] b;
      logic [31:0]          shift;
      int                   waited;
      start    = 1'b0;
      op       = opMul;
      operandA = '0;
      operandB = '0;
      waited   = 0;
      while (rstN !== 1'b1 && waited < 100) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (rstN !== 1'b1) begin
         timeoutErrors++;
         $display("Timeout while waiting for reset to be released");
      end
      @(posedge clk);
      #1;
      if (busy !== 1'b0 || done !== 1'b0 || resultHi !== '0 || resultLo !== '0) begin
         valueErrors++;
         $display("[FAIL] reset state: busy 0x%h done 0x%h resultHi 0x%h resultLo 0x%h",
                  busy, done, resultHi, resultLo);
      end

      runOp(opMul, '0, '0);
      runOp(opMul, '0, 32'h1234_5678);
      runOp(opMul, 32'h1, 32'hdead_beef);
      runOp(opMul, 32'hcafe_f00d, 32'h1);
      runOp(opMul, '1, '1);
      runOp(opMul, '1, 32'h1);
      for (int i = 0; i < 24; i++) begin
         runOp(opMul, randWord(), randWord());
      end

      runOp(opDiv, 32'd5, 32'd7);                 // Dividend below divisor.
      runOp(opDiv, 32'h8765_4321, 32'h8765_4321);
      runOp(opDiv, 32'h0bad_cafe, 32'h1);
      runOp(opDiv, '1, '1);
      runOp(opDiv, '0, 32'd5);
      runOp(opDiv, '1, 32'd2);
      for (int i = 0; i < 24; i++) begin
         a     = randWord();
         shift = randWord();
         b     = randWord() >> shift[4:0];
         runOp(opDiv, a, b);
      end

      runOp(opDiv, 32'h1357_9bdf, '0);
      runOp(opDiv, '0, '0);
      runOp(opDiv, '1, '0);

      // A second start while busy must be dropped.
      runOp(opMul, 32'h0000_abcd, 32'h0001_0001);
      repeat (5) begin
         @(posedge clk);
         #1;
      end
      if (busy !== 1'b1) begin
         protocolErrors++;
         $display("The unit was not busy when the extra start was driven");
      end
      start    = 1'b1;
      op       = opDiv;
      operandA = randWord();
      operandB = randWord();
      @(posedge clk);
      #1;
      start = 1'b0;

      // Starts land in the first cycle after each done.
      for (int i = 0; i < 10; i++) begin
         runOp((i % 2 == 0) ? opMul : opDiv, randWord(), randWord() >> (i + 1));
      end

      waited = 0;
      while (expCycleQ.size() > 0 && waited < 2 * OpTimeout) begin
         @(posedge clk);
         #1;
         waited++;
      end
      repeat (2 * DataWidth) begin   // Room for a stray done to show up.
         @(posedge clk);
         #1;
      end
      finishRun();
   end

   initial begin : watchdog
      repeat (GlobalLimit) @(posedge clk);
      timeoutErrors++;
      $display("Timeout: the run did not complete within the cycle limit");
      finishRun();
   end

endmodule

// File: all.f
source/mulDivPkg.sv
source/mulDivCtrlIf.sv
source/addSub.sv
source/stepCounter.sv
source/mulDivControl.sv
source/mulDivDatapath.sv
source/mulDivUnit.sv
bench/clockGen.sv
bench/mulDivBench.sv
